// ==== source/median_pkg.sv ====
package median_pkg;

  localparam int PIX_W = 8;
  localparam int WIN = 7;                    // window side.
  localparam int WIN_N = WIN * WIN;

  // 25 candidates survive pruning, so the median sits at rank 12.
  localparam int CAND_N = 25;
  localparam int MEDIAN_RANK = 12;
  localparam int CNT_W = $clog2(CAND_N + 1);

  // row input reg, row sort, column sort, prune, two rank stages.
  localparam int LATENCY = 6;

  typedef logic [PIX_W-1:0] pixel_t;

  // element 0 is the smallest once sorted.
  typedef pixel_t [WIN-1:0] row7_t;

  // row-major window, element r*WIN+c is row r, column c.
  typedef pixel_t [WIN_N-1:0] window_t;

  typedef pixel_t [CAND_N-1:0] cand_t;

  typedef logic [CNT_W-1:0] count_t;        // holds 0 to CAND_N.

endpackage

// ==== source/sort7.sv ====
module sort7 (
  input  logic               clk,
  input  logic               rst,
  input  median_pkg::row7_t  in_i,
  input  logic               valid_i,
  output median_pkg::row7_t  out_o,
  output logic               valid_o
);

  localparam int N = median_pkg::WIN;

  median_pkg::row7_t  net;  // values as they move through the network.
  median_pkg::pixel_t lo;
  median_pkg::pixel_t hi;

  // odd-even transposition network.
  // even rounds compare (0,1) (2,3) (4,5), odd rounds compare (1,2) (3,4) (5,6).
  // seven rounds are enough to order seven values.
  always_comb begin
    net = in_i;
    lo  = '0;
    hi  = '0;
    for (int r = 0; r < N; r++) begin
      for (int i = 0; i < N - 1; i++) begin
        if ((i % 2) == (r % 2)) begin
          lo = (net[i+1] < net[i]) ? net[i+1] : net[i];
          hi = (net[i+1] < net[i]) ? net[i] : net[i+1];
          net[i]   = lo;
          net[i+1] = hi;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_o   <= '0;
      valid_o <= 1'b0;
    end else begin
      out_o   <= net;  // ascending, index 0 is the minimum.
      valid_o <= valid_i;
    end
  end

endmodule

// ==== source/median7_row_sort.sv ====
module median7_row_sort (
  input  logic                clk,
  input  logic                rst,
  input  median_pkg::window_t window_i,
  input  logic                valid_i,
  output median_pkg::window_t sorted_o,
  output logic                valid_o
);

  localparam int W = median_pkg::WIN;

  median_pkg::window_t win_q;
  logic                win_valid_q;
  median_pkg::row7_t   row_out [W];

  always_ff @(posedge clk) begin
    if (rst) begin
      win_q       <= '0;
      win_valid_q <= 1'b0;
    end else begin
      win_q       <= window_i;
      win_valid_q <= valid_i;
    end
  end

  // one sorter per row, the first one carries the strobe.
  for (genvar r = 0; r < W; r++) begin : g_row
    if (r == 0) begin : g_lead
      sort7 i_sort7 (
        .clk     (clk),
        .rst     (rst),
        .in_i    (win_q[r*W +: W]),
        .valid_i (win_valid_q),
        .out_o   (row_out[r]),
        .valid_o (valid_o)
      );
    end else begin : g_follow
      sort7 i_sort7 (
        .clk     (clk),
        .rst     (rst),
        .in_i    (win_q[r*W +: W]),
        .valid_i (win_valid_q),
        .out_o   (row_out[r]),
        .valid_o ()
      );
    end
  end

  always_comb begin
    for (int r = 0; r < W; r++) begin
      sorted_o[r*W +: W] = row_out[r];
    end
  end

endmodule

// ==== source/median7_col_sort.sv ====
module median7_col_sort (
  input  logic                clk,
  input  logic                rst,
  input  median_pkg::window_t rows_i,
  input  logic                valid_i,
  output median_pkg::window_t grid_o,
  output logic                valid_o
);

  localparam int W = median_pkg::WIN;

  median_pkg::row7_t col_in  [W];
  median_pkg::row7_t col_out [W];

  // sorter k collects the rank-k value of every row.
  always_comb begin
    for (int k = 0; k < W; k++) begin
      for (int r = 0; r < W; r++) begin
        col_in[k][r] = rows_i[r*W + k];
      end
    end
  end

  for (genvar k = 0; k < W; k++) begin : g_col
    if (k == 0) begin : g_lead
      sort7 i_sort7 (
        .clk     (clk),
        .rst     (rst),
        .in_i    (col_in[k]),
        .valid_i (valid_i),
        .out_o   (col_out[k]),
        .valid_o (valid_o)
      );
    end else begin : g_follow
      sort7 i_sort7 (
        .clk     (clk),
        .rst     (rst),
        .in_i    (col_in[k]),
        .valid_i (valid_i),
        .out_o   (col_out[k]),
        .valid_o ()
      );
    end
  end

  // grid row k is the sorted rank-k column, ascending along both axes.
  always_comb begin
    for (int k = 0; k < W; k++) begin
      grid_o[k*W +: W] = col_out[k];
    end
  end

endmodule

// ==== source/median7_prune.sv ====
module median7_prune (
  input  logic                clk,
  input  logic                rst,
  input  median_pkg::window_t grid_i,
  input  logic                valid_i,
  output median_pkg::cand_t   cand_o,
  output logic                valid_o
);

  localparam int W = median_pkg::WIN;

  typedef median_pkg::pixel_t [2:0] trio_t;

  trio_t             ul_sorted;  // cells (2,2) (3,1) (4,0).
  trio_t             lr_sorted;  // cells (2,6) (3,5) (4,4).
  median_pkg::cand_t cand_d;

  function automatic trio_t sort3(input median_pkg::pixel_t a, input median_pkg::pixel_t b,
                                  input median_pkg::pixel_t c);
    median_pkg::pixel_t x;
    median_pkg::pixel_t y;
    median_pkg::pixel_t z;
    x = (a < b) ? a : b;
    y = (a < b) ? b : a;
    z = (y < c) ? c : y;
    y = (y < c) ? y : c;
    if (y < x) begin
      y = x ^ y;
      x = x ^ y;
      y = x ^ y;
    end
    return {z, y, x};  // index 0 holds the smallest.
  endfunction

  assign ul_sorted = sort3(grid_i[2*W+2], grid_i[3*W+1], grid_i[4*W+0]);
  assign lr_sorted = sort3(grid_i[2*W+6], grid_i[3*W+5], grid_i[4*W+4]);

  // cells with k+j below 4 or above 8 cannot hold the median.
  always_comb begin
    cand_d[0]  = grid_i[5*W+0];
    cand_d[1]  = grid_i[6*W+0];
    cand_d[2]  = grid_i[4*W+1];
    cand_d[3]  = grid_i[5*W+1];
    cand_d[4]  = grid_i[6*W+1];
    cand_d[5]  = ul_sorted[2];    // only the largest of the lower corner stays.
    cand_d[6]  = grid_i[3*W+2];
    cand_d[7]  = grid_i[4*W+2];
    cand_d[8]  = grid_i[5*W+2];
    cand_d[9]  = grid_i[6*W+2];
    cand_d[10] = grid_i[1*W+3];
    cand_d[11] = grid_i[2*W+3];
    cand_d[12] = grid_i[3*W+3];
    cand_d[13] = grid_i[4*W+3];
    cand_d[14] = grid_i[5*W+3];
    cand_d[15] = grid_i[0*W+4];
    cand_d[16] = grid_i[1*W+4];
    cand_d[17] = grid_i[2*W+4];
    cand_d[18] = grid_i[3*W+4];
    cand_d[19] = lr_sorted[0];    // only the smallest of the upper corner stays.
    cand_d[20] = grid_i[0*W+5];
    cand_d[21] = grid_i[1*W+5];
    cand_d[22] = grid_i[2*W+5];
    cand_d[23] = grid_i[0*W+6];
    cand_d[24] = grid_i[1*W+6];
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cand_o  <= '0;
      valid_o <= 1'b0;
    end else begin
      cand_o  <= cand_d;
      valid_o <= valid_i;
    end
  end

endmodule

// ==== source/median_rank_select.sv ====
module median_rank_select (
  input  logic               clk,
  input  logic               rst,
  input  median_pkg::cand_t  cand_i,
  input  logic               valid_i,
  output median_pkg::pixel_t median_o,
  output logic               valid_o
);

  localparam int N = median_pkg::CAND_N;
  localparam median_pkg::count_t RANK = median_pkg::count_t'(median_pkg::MEDIAN_RANK);

  median_pkg::count_t lt_d [N];  // candidates strictly smaller.
  median_pkg::count_t le_d [N];  // candidates smaller or equal, self included.
  median_pkg::count_t lt_q [N];
  median_pkg::count_t le_q [N];
  median_pkg::cand_t  cand_q;
  logic               valid_q;
  median_pkg::pixel_t median_d;

  always_comb begin
    for (int i = 0; i < N; i++) begin
      lt_d[i] = '0;
      le_d[i] = '0;
      for (int j = 0; j < N; j++) begin
        lt_d[i] = lt_d[i] + median_pkg::count_t'(cand_i[j] < cand_i[i]);
        le_d[i] = le_d[i] + median_pkg::count_t'(cand_i[j] <= cand_i[i]);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < N; i++) begin
        lt_q[i] <= '0;
        le_q[i] <= '0;
      end
      cand_q  <= '0;
      valid_q <= 1'b0;
    end else begin
      for (int i = 0; i < N; i++) begin
        lt_q[i] <= lt_d[i];
        le_q[i] <= le_d[i];
      end
      cand_q  <= cand_i;
      valid_q <= valid_i;
    end
  end

  // a value whose rank range covers RANK is the median.
  // scanning downward leaves the lowest matching index.
  always_comb begin
    median_d = '0;
    for (int i = N - 1; i >= 0; i--) begin
      if (lt_q[i] <= RANK && le_q[i] > RANK) begin
        median_d = cand_q[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      median_o <= '0;
      valid_o  <= 1'b0;
    end else begin
      median_o <= median_d;
      valid_o  <= valid_q;
    end
  end

endmodule

// ==== source/median7_filter.sv ====
module median7_filter (
  input  logic                clk,
  input  logic                rst,
  input  median_pkg::window_t window_i,
  input  logic                window_valid_i,
  output median_pkg::pixel_t  median_o,
  output logic                median_valid_o
);

  median_pkg::window_t row_sorted;
  logic                row_valid;
  median_pkg::window_t grid;
  logic                grid_valid;
  median_pkg::cand_t   cand;
  logic                cand_valid;

  median7_row_sort i_row_sort (
    .clk      (clk),
    .rst      (rst),
    .window_i (window_i),
    .valid_i  (window_valid_i),
    .sorted_o (row_sorted),
    .valid_o  (row_valid)
  );

  median7_col_sort i_col_sort (
    .clk     (clk),
    .rst     (rst),
    .rows_i  (row_sorted),
    .valid_i (row_valid),
    .grid_o  (grid),
    .valid_o (grid_valid)
  );

  median7_prune i_prune (
    .clk     (clk),
    .rst     (rst),
    .grid_i  (grid),
    .valid_i (grid_valid),
    .cand_o  (cand),
    .valid_o (cand_valid)
  );

  median_rank_select i_rank_select (
    .clk      (clk),
    .rst      (rst),
    .cand_i   (cand),
    .valid_i  (cand_valid),
    .median_o (median_o),
    .valid_o  (median_valid_o)
  );

endmodule

// ==== sim/median_model.svh ====
`ifndef MEDIAN_MODEL_SVH
`define MEDIAN_MODEL_SVH

// sorts all 49 pixels and returns index 24.
function automatic median_pkg::pixel_t model_median(input median_pkg::window_t w);
  int v [median_pkg::WIN_N];
  int key;
  int j;
  for (int i = 0; i < median_pkg::WIN_N; i++) begin
    v[i] = int'(w[i]);
  end
  for (int i = 1; i < median_pkg::WIN_N; i++) begin
    key = v[i];
    j = i - 1;
    while (j >= 0 && v[j] > key) begin
      v[j+1] = v[j];
      j = j - 1;
    end
    v[j+1] = key;
  end
  return median_pkg::pixel_t'(v[median_pkg::WIN_N / 2]);
endfunction

function automatic median_pkg::window_t random_window();
  median_pkg::window_t w;
  for (int i = 0; i < median_pkg::WIN_N; i++) begin
    w[i] = median_pkg::pixel_t'($random(seed));
  end
  return w;
endfunction

function automatic median_pkg::window_t flat_window(input median_pkg::pixel_t p);
  median_pkg::window_t w;
  for (int i = 0; i < median_pkg::WIN_N; i++) begin
    w[i] = p;
  end
  return w;
endfunction

function automatic median_pkg::window_t ramp_window(input logic up);
  median_pkg::window_t w;
  for (int i = 0; i < median_pkg::WIN_N; i++) begin
    w[i] = median_pkg::pixel_t'(up ? i : median_pkg::WIN_N - 1 - i);
  end
  return w;
endfunction

// fisher-yates shuffle of the 0..48 ramp.
function automatic median_pkg::window_t shuffled_ramp_window();
  median_pkg::window_t w;
  median_pkg::pixel_t tmp;
  int j;
  w = ramp_window(1'b1);
  for (int i = median_pkg::WIN_N - 1; i > 0; i--) begin
    j = int'($unsigned($random(seed)) % (i + 1));
    tmp = w[i];
    w[i] = w[j];
    w[j] = tmp;
  end
  return w;
endfunction

// mostly black and white, a few mid greys.
function automatic median_pkg::window_t bimodal_window();
  median_pkg::window_t w;
  int unsigned r;
  for (int i = 0; i < median_pkg::WIN_N; i++) begin
    r = $unsigned($random(seed)) % 10;
    if (r < 4) begin
      w[i] = '0;
    end else if (r < 8) begin
      w[i] = '1;
    end else begin
      w[i] = median_pkg::pixel_t'($random(seed));
    end
  end
  return w;
endfunction

function automatic median_pkg::window_t duplicate_window();
  median_pkg::window_t w;
  median_pkg::pixel_t a;
  median_pkg::pixel_t b;
  median_pkg::pixel_t c;
  int unsigned pick;
  a = median_pkg::pixel_t'($random(seed));
  b = median_pkg::pixel_t'($random(seed));
  c = median_pkg::pixel_t'($random(seed));
  for (int i = 0; i < median_pkg::WIN_N; i++) begin
    pick = $unsigned($random(seed)) % 3;
    w[i] = (pick == 0) ? a : ((pick == 1) ? b : c);
  end
  return w;
endfunction

`endif

// ==== sim/tb_median7.sv ====
module tb_median7;
  timeunit 1ns;
  timeprecision 1ps;

  typedef int unsigned cycle_t;

  localparam int N_B2B = 2000;
  localparam int N_GAP = 1000;
  localparam int N_SHUF = 20;
  localparam int N_BIMODAL = 50;
  localparam int N_DUP = 50;
  localparam int N_STRUCT = 5 + N_SHUF + N_BIMODAL + N_DUP;
  localparam int N_PRE_RST = 20;
  localparam int N_POST_RST = 200;
  localparam int TOTAL_WIN = N_B2B + N_GAP + N_STRUCT + N_PRE_RST + N_POST_RST;
  localparam int WATCHDOG_CYCLES = TOTAL_WIN * 8 + 200;

  logic                clk;
  logic                rst;
  median_pkg::window_t window_i;
  logic                window_valid_i;
  median_pkg::pixel_t  median_o;
  logic                median_valid_o;

  integer             seed;
  cycle_t             cycle = 0;
  median_pkg::pixel_t exp_q [$];  // expected medians in arrival order.
  cycle_t             due_q [$];
  median_pkg::pixel_t exp_px;
  cycle_t             due_cyc;
  logic               rst_prev = 1'b0;
  int                 n_in = 0;
  int                 n_out = 0;
  int                 sent;

  `include "median_model.svh"

  median7_filter i_dut (
    .clk            (clk),
    .rst            (rst),
    .window_i       (window_i),
    .window_valid_i (window_valid_i),
    .median_o       (median_o),
    .median_valid_o (median_valid_o)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
  end

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display(">>> FAIL");
    $fatal(1);
  endtask

  task automatic check_median(input median_pkg::pixel_t got, input median_pkg::pixel_t expected);
    if (got !== expected) begin
      stop_with_failure($sformatf("mismatch at %0t: median %0d, expected %0d",
                                  $time, got, expected));
    end
  endtask

  task automatic verify_arrival_time(input cycle_t got, input cycle_t expected);
    if (got != expected) begin
      stop_with_failure($sformatf("mismatch at %0t: median arrived in cycle %0d, expected %0d",
                                  $time, got, expected));
    end
  endtask

  task automatic send_window(input median_pkg::window_t w);
    @(posedge clk);
    window_i       <= w;
    window_valid_i <= 1'b1;
  endtask

  // garbage on the data lines, no strobe.
  task automatic idle_cycle();
    @(posedge clk);
    window_i       <= random_window();
    window_valid_i <= 1'b0;
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    rst            <= 1'b1;
    window_valid_i <= 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  // outputs and the input strobe are sampled half a cycle after the drive edge.
  always @(negedge clk) begin
    if (rst_prev && median_valid_o) begin
      stop_with_failure("median_valid_o was high in the cycle after reset");
    end
    if (rst) begin
      exp_q.delete();
      due_q.delete();
      n_in  = 0;
      n_out = 0;
    end else begin
      if (median_valid_o) begin
        if (exp_q.size() == 0) begin
          stop_with_failure("median_valid_o went high with no window outstanding");
        end else begin
          exp_px  = exp_q.pop_front();
          due_cyc = due_q.pop_front();
          check_median(median_o, exp_px);
          verify_arrival_time(cycle, due_cyc);
          n_out = n_out + 1;
        end
      end
      if (window_valid_i) begin
        exp_q.push_back(model_median(window_i));
        due_q.push_back(cycle + cycle_t'(median_pkg::LATENCY));
        n_in = n_in + 1;
      end
    end
    rst_prev = rst;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    stop_with_failure("timeout, the run did not finish in time");
  end

  initial begin
    seed           = 32'h94153674;
    rst            = 1'b1;
    window_i       = '0;
    window_valid_i = 1'b0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    repeat (N_B2B) send_window(random_window());

    sent = 0;
    while (sent < N_GAP) begin
      if ($unsigned($random(seed)) % 100 < 40) begin
        idle_cycle();
      end else begin
        send_window(random_window());
        sent = sent + 1;
      end
    end

    send_window(flat_window(8'd0));
    send_window(flat_window(8'd255));
    send_window(flat_window(median_pkg::pixel_t'($random(seed))));
    send_window(ramp_window(1'b1));
    send_window(ramp_window(1'b0));
    repeat (N_SHUF) send_window(shuffled_ramp_window());
    repeat (N_BIMODAL) send_window(bimodal_window());
    repeat (N_DUP) send_window(duplicate_window());

    // windows still in flight are dropped by the reset.
    repeat (N_PRE_RST) send_window(random_window());
    pulse_reset();
    repeat (N_POST_RST) send_window(random_window());

    repeat (median_pkg::LATENCY + 2) idle_cycle();

    if (exp_q.size() != 0 || n_out != n_in) begin
      stop_with_failure($sformatf("run ended with %0d of %0d windows never answered",
                                  n_in - n_out, n_in));
    end else begin
      $display("%0d medians checked since the last reset", n_out);
      $display(">>> PASS");
      $finish;
    end
  end

endmodule

// ==== list.f ====
+incdir+sim
source/median_pkg.sv
source/sort7.sv
source/median7_row_sort.sv
source/median7_col_sort.sv
source/median7_prune.sv
source/median_rank_select.sv
source/median7_filter.sv
sim/tb_median7.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the median filter testbench with Verilator.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing -j 0 \
  --top-module tb_median7 \
  -f list.f \
  -o tb_median7 \
  && ./obj_dir/tb_median7 2>&1 | tee sim.log

grep -qx '>>> PASS' sim.log \
  && echo "simulation passed" \
  || { echo "simulation failed, see sim.log"; exit 1; }
